// ==== common/lc4_pkg.sv ====
/*
 * LC4 core shared definitions
 * Widths, opcodes and sub-opcodes, stall codes, ALU operations,
 * the instruction word views and the pipeline register structs
 */
package lc4_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NUM_REGS  = 8;

   localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // Bits [5:3] of the register-register forms
   localparam logic [2:0] SUBOP_ADD = 3'b000;
   localparam logic [2:0] SUBOP_SUB = 3'b010;
   localparam logic [2:0] SUBOP_AND = 3'b000;
   localparam logic [2:0] SUBOP_OR  = 3'b010;
   localparam logic [2:0] SUBOP_XOR = 3'b011;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;
   typedef logic [2:0]           nzp_t;     // {n, z, p}

   typedef enum logic [1:0] {
      STALL_NONE     = 2'd0,
      STALL_FLUSH    = 2'd2,  // Flushed slot, also the reset value
      STALL_LOAD_USE = 2'd3
   } stall_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef union packed {
      struct packed {
         logic [3:0] opcode;
         reg_sel_t   rd;
         reg_sel_t   rs;
         logic [2:0] subop;
         reg_sel_t   rt;
      } rrr;
      struct packed {
         logic [3:0] opcode;
         reg_sel_t   rd;
         reg_sel_t   rs;
         logic [5:0] imm6;    // Bit 5 selects ADD-immediate in OP_ARITH
      } rri;
      struct packed {
         logic [3:0] opcode;
         logic [2:0] nzp_rd;  // NZP mask for BR, rd for CONST
         logic [8:0] imm9;
      } ri9;
   } insn_u;

   typedef struct packed {
      logic     regfile_we;
      reg_sel_t wsel;
      reg_sel_t r1sel;
      logic     r1_re;
      reg_sel_t r2sel;
      logic     r2_re;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      alu_op_e  alu_op;
      logic     use_imm;
      word_t    imm;        // Already sign extended
   } ctrl_t;

   typedef struct packed {
      word_t  pc;
      insn_u  insn;
      stall_e stall;
   } d_reg_t;

   typedef struct packed {
      word_t  pc;
      insn_u  insn;
      stall_e stall;
      ctrl_t  ctrl;
      word_t  r1data;
      word_t  r2data;
   } x_reg_t;

   typedef struct packed {
      word_t  pc;
      insn_u  insn;
      stall_e stall;
      ctrl_t  ctrl;
      word_t  result;     // ALU output, also the memory address
      word_t  r2data;
      nzp_t   nzp;
   } m_reg_t;

   typedef struct packed {
      word_t    pc;
      insn_u    insn;
      stall_e   stall;
      logic     regfile_we;
      reg_sel_t wsel;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      word_t    result;
      word_t    load_data;
      nzp_t     nzp;
   } w_reg_t;

   typedef struct packed {
      logic     we;
      reg_sel_t wsel;
      word_t    wdata;
   } wb_port_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

   typedef struct packed {
      stall_e   stall;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp;
   } retire_t;

   // Condition code of a result word
   function automatic nzp_t nzp_of(word_t value);
      if (value[WORD_W-1]) begin
         return 3'b100;
      end
      if (value == '0) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

endpackage

// ==== src/lc4_fetch.sv ====
/*
 * Fetch stage
 * PC register, next-PC choice and the decode pipeline register
 */
`timescale 1ns/1ps

module lc4_fetch (
   input  logic                gwe,
   input  logic                i_rst_n,
   input  lc4_pkg::word_t      i_imem_data,
   input  logic                i_load_use,
   input  lc4_pkg::redirect_t  i_redirect,
   output lc4_pkg::word_t      o_imem_addr,
   output lc4_pkg::d_reg_t     o_d
);
   import lc4_pkg::*;

   word_t  pc_q;
   word_t  pc_next;
   d_reg_t d_q;

   // Hold wins, a redirect from execute comes next
   assign pc_next = i_load_use       ? pc_q :
                    i_redirect.taken ? i_redirect.target :
                                       pc_q + WORD_W'(1);

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_load_use) begin
         d_q.pc   <= pc_q;
         d_q.insn <= i_imem_data;
      end
      if (!i_rst_n) begin
         d_q.stall <= STALL_FLUSH;
      end else if (!i_load_use) begin
         d_q.stall <= i_redirect.taken ? STALL_FLUSH : STALL_NONE; // Wrong-path slot
      end
   end

   assign o_imem_addr = pc_q;
   assign o_d         = d_q;

   // Loads and branches cannot both sit in execute
   a_no_stall_and_redirect : assert property (
      @(posedge gwe) disable iff (!i_rst_n) !(i_load_use && i_redirect.taken))
      else $error("load-use stall and redirect in the same cycle");

endmodule

// ==== decode/lc4_decoder.sv ====
/*
 * Instruction decoder for the kept LC4 subset
 * Maps an instruction word onto the pipeline control struct
 */
`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_pkg::insn_u  i_insn,
   output lc4_pkg::ctrl_t  o_ctrl
);
   import lc4_pkg::*;

   always_comb begin
      o_ctrl            = '0;
      o_ctrl.alu_op     = ALU_ADD;
      o_ctrl.wsel       = i_insn.rrr.rd;
      o_ctrl.r1sel      = i_insn.rrr.rs;
      o_ctrl.r2sel      = i_insn.rrr.rt;

      case (i_insn.rrr.opcode)
         OP_BR: begin
            o_ctrl.is_branch = 1'b1;
            o_ctrl.imm       = {{(WORD_W-9){i_insn.ri9.imm9[8]}}, i_insn.ri9.imm9};
         end
         OP_ARITH: begin
            if (i_insn.rri.imm6[5]) begin             // ADD with imm5
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.r1_re      = 1'b1;
               o_ctrl.use_imm    = 1'b1;
               o_ctrl.imm = {{(WORD_W-5){i_insn.rri.imm6[4]}}, i_insn.rri.imm6[4:0]};
            end else if (i_insn.rrr.subop == SUBOP_ADD || i_insn.rrr.subop == SUBOP_SUB) begin
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.r1_re      = 1'b1;
               o_ctrl.r2_re      = 1'b1;
               o_ctrl.alu_op     = (i_insn.rrr.subop == SUBOP_SUB) ? ALU_SUB : ALU_ADD;
            end
         end
         OP_LOGIC: begin
            if (i_insn.rrr.subop == SUBOP_AND || i_insn.rrr.subop == SUBOP_OR ||
                i_insn.rrr.subop == SUBOP_XOR) begin
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.r1_re      = 1'b1;
               o_ctrl.r2_re      = 1'b1;
               o_ctrl.alu_op     = (i_insn.rrr.subop == SUBOP_AND) ? ALU_AND :
                                   (i_insn.rrr.subop == SUBOP_OR)  ? ALU_OR  : ALU_XOR;
            end
         end
         OP_LDR, OP_STR: begin
            o_ctrl.r1_re   = 1'b1;                     // Base register
            o_ctrl.use_imm = 1'b1;
            o_ctrl.imm     = {{(WORD_W-6){i_insn.rri.imm6[5]}}, i_insn.rri.imm6};
            if (i_insn.rri.opcode == OP_LDR) begin
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.is_load    = 1'b1;
            end else begin
               o_ctrl.is_store = 1'b1;
               o_ctrl.r2_re    = 1'b1;
               o_ctrl.r2sel    = i_insn.rri.rd;          // Store data register
            end
         end
         OP_CONST: begin
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we     = 1'b1;
            o_ctrl.use_imm    = 1'b1;
            o_ctrl.alu_op     = ALU_PASS_B;
            o_ctrl.imm        = {{(WORD_W-9){i_insn.ri9.imm9[8]}}, i_insn.ri9.imm9};
         end
         default: ;                                   // Retires with no effect
      endcase
   end

endmodule

// ==== decode/lc4_regfile.sv ====
/*
 * Eight-entry register file
 * Two read ports, one write port, write-through to the reads
 */
`timescale 1ns/1ps

module lc4_regfile (
   input  logic               gwe,
   input  logic               i_rst_n,
   input  lc4_pkg::reg_sel_t  i_r1sel,
   input  lc4_pkg::reg_sel_t  i_r2sel,
   input  lc4_pkg::wb_port_t  i_wb,
   output lc4_pkg::word_t     o_r1data,
   output lc4_pkg::word_t     o_r2data
);
   import lc4_pkg::*;

   word_t regs_q [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (i_wb.we) begin
         regs_q[i_wb.wsel] <= i_wb.wdata;
      end
   end

   // Writeback in W shows through to the decode read
   assign o_r1data = (i_wb.we && (i_wb.wsel == i_r1sel)) ? i_wb.wdata : regs_q[i_r1sel];
   assign o_r2data = (i_wb.we && (i_wb.wsel == i_r2sel)) ? i_wb.wdata : regs_q[i_r2sel];

   a_wsel_known : assert property (
      @(posedge gwe) disable iff (!i_rst_n) i_wb.we |-> !$isunknown(i_wb.wsel))
      else $error("register write with unknown wsel");

endmodule

// ==== decode/lc4_decode_stage.sv ====
/*
 * Decode stage
 * Load-to-use hazard check and the execute pipeline register
 */
`timescale 1ns/1ps

module lc4_decode_stage (
   input  logic                gwe,
   input  logic                i_rst_n,
   input  lc4_pkg::d_reg_t     i_d,
   input  lc4_pkg::wb_port_t   i_wb,
   input  lc4_pkg::redirect_t  i_redirect,
   output logic                o_load_use,
   output lc4_pkg::x_reg_t     o_x
);
   import lc4_pkg::*;

   ctrl_t  ctrl;
   word_t  r1data;
   word_t  r2data;
   x_reg_t x_q;
   logic   x_load;
   logic   dep_hit;

   lc4_decoder i_lc4_decoder (
      .i_insn (i_d.insn),
      .o_ctrl (ctrl)
   );

   lc4_regfile i_lc4_regfile (
      .gwe      (gwe),
      .i_rst_n  (i_rst_n),
      .i_r1sel  (ctrl.r1sel),
      .i_r2sel  (ctrl.r2sel),
      .i_wb     (i_wb),
      .o_r1data (r1data),
      .o_r2data (r2data)
   );

   assign x_load  = (x_q.stall == STALL_NONE) && x_q.ctrl.is_load;

   // Store data goes through the W-to-M path, so r2 of a store never stalls
   assign dep_hit = (ctrl.r1_re && (ctrl.r1sel == x_q.ctrl.wsel)) ||
                    (ctrl.r2_re && !ctrl.is_store && (ctrl.r2sel == x_q.ctrl.wsel)) ||
                    ctrl.is_branch;                 // Branch waits for the load's NZP

   assign o_load_use = (i_d.stall == STALL_NONE) && x_load && dep_hit;

   always_ff @(posedge gwe) begin
      x_q.pc     <= i_d.pc;
      x_q.insn   <= i_d.insn;
      x_q.ctrl   <= ctrl;
      x_q.r1data <= r1data;
      x_q.r2data <= r2data;
      if (!i_rst_n) begin
         x_q.stall <= STALL_FLUSH;
      end else if (i_redirect.taken) begin
         x_q.stall <= STALL_FLUSH;
      end else if (o_load_use) begin
         x_q.stall <= STALL_LOAD_USE;                // Bubble, D holds
      end else begin
         x_q.stall <= i_d.stall;
      end
   end

   assign o_x = x_q;

endmodule

// ==== execute/lc4_execute.sv ====
/*
 * Execute stage
 * Operand bypass, ALU and NZP, branch resolution,
 * and the memory pipeline register
 */
`timescale 1ns/1ps

module lc4_execute (
   input  logic                gwe,
   input  logic                i_rst_n,
   input  lc4_pkg::x_reg_t     i_x,
   input  lc4_pkg::wb_port_t   i_wb,
   input  lc4_pkg::nzp_t       i_nzp_cur,
   output lc4_pkg::redirect_t  o_redirect,
   output lc4_pkg::m_reg_t     o_m
);
   import lc4_pkg::*;

   m_reg_t m_q;
   logic   x_valid;
   logic   m_valid;
   logic   m_fwd;
   logic   m_nzp_fwd;
   word_t  op_a;
   word_t  op_b_reg;
   word_t  op_b;
   word_t  alu_res;
   nzp_t   br_nzp;

   assign x_valid   = (i_x.stall == STALL_NONE);
   assign m_valid   = (m_q.stall == STALL_NONE);
   assign m_fwd     = m_valid && m_q.ctrl.regfile_we && !m_q.ctrl.is_load;
   assign m_nzp_fwd = m_valid && m_q.ctrl.nzp_we && !m_q.ctrl.is_load;

   // M first, then W, then the value read in decode
   function automatic word_t fwd_operand(reg_sel_t sel, word_t decoded);
      if (m_fwd && (m_q.ctrl.wsel == sel)) begin
         return m_q.result;
      end
      if (i_wb.we && (i_wb.wsel == sel)) begin
         return i_wb.wdata;
      end
      return decoded;
   endfunction

   always_comb begin
      op_a     = fwd_operand(i_x.ctrl.r1sel, i_x.r1data);
      op_b_reg = fwd_operand(i_x.ctrl.r2sel, i_x.r2data);
   end

   assign op_b = i_x.ctrl.use_imm ? i_x.ctrl.imm : op_b_reg;

   always_comb begin
      case (i_x.ctrl.alu_op)
         ALU_ADD: alu_res = op_a + op_b;            // Also LDR/STR address
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_XOR: alu_res = op_a ^ op_b;
         default: alu_res = op_b;
      endcase
   end

   // A load in M never meets a branch here, the stall keeps them apart
   assign br_nzp = m_nzp_fwd ? m_q.nzp : i_nzp_cur;

   assign o_redirect.taken  = x_valid && i_x.ctrl.is_branch &&
                              (|(i_x.insn.ri9.nzp_rd & br_nzp));
   assign o_redirect.target = i_x.pc + WORD_W'(1) + i_x.ctrl.imm;

   always_ff @(posedge gwe) begin
      m_q.pc     <= i_x.pc;
      m_q.insn   <= i_x.insn;
      m_q.ctrl   <= i_x.ctrl;
      m_q.result <= alu_res;
      m_q.r2data <= op_b_reg;                      // Bypassed store data
      m_q.nzp    <= nzp_of(alu_res);
      if (!i_rst_n) begin
         m_q.stall <= STALL_FLUSH;
      end else begin
         m_q.stall <= i_x.stall;
      end
   end

   assign o_m = m_q;

endmodule

// ==== src/lc4_writeback.sv ====
/*
 * Memory and writeback stages
 * Data memory drive, W register, writeback select,
 * NZP register and the retirement record
 */
`timescale 1ns/1ps

module lc4_writeback (
   input  logic               gwe,
   input  logic               i_rst_n,
   input  lc4_pkg::m_reg_t    i_m,
   input  lc4_pkg::word_t     i_dmem_rdata,
   output lc4_pkg::word_t     o_dmem_addr,
   output lc4_pkg::word_t     o_dmem_wdata,
   output logic               o_dmem_we,
   output lc4_pkg::wb_port_t  o_wb,
   output lc4_pkg::nzp_t      o_nzp_cur,
   output lc4_pkg::retire_t   o_retire
);
   import lc4_pkg::*;

   w_reg_t w_q;
   nzp_t   nzp_q;
   logic   w_valid;
   word_t  wdata;
   nzp_t   w_nzp;

   assign w_valid = (w_q.stall == STALL_NONE);
   assign wdata   = w_q.is_load ? w_q.load_data : w_q.result;
   assign w_nzp   = w_q.is_load ? nzp_of(w_q.load_data) : w_q.nzp;

   assign o_dmem_addr  = i_m.result;
   assign o_dmem_we    = (i_m.stall == STALL_NONE) && i_m.ctrl.is_store;
   // W-to-M bypass covers a store right behind a load
   assign o_dmem_wdata = (o_wb.we && (o_wb.wsel == i_m.ctrl.r2sel)) ? wdata : i_m.r2data;

   always_ff @(posedge gwe) begin
      w_q.pc         <= i_m.pc;
      w_q.insn       <= i_m.insn;
      w_q.regfile_we <= i_m.ctrl.regfile_we;
      w_q.wsel       <= i_m.ctrl.wsel;
      w_q.nzp_we     <= i_m.ctrl.nzp_we;
      w_q.is_load    <= i_m.ctrl.is_load;
      w_q.result     <= i_m.result;
      w_q.load_data  <= i_dmem_rdata;
      w_q.nzp        <= i_m.nzp;
      if (!i_rst_n) begin
         w_q.stall <= STALL_FLUSH;
         nzp_q     <= '0;
      end else begin
         w_q.stall <= i_m.stall;
         if (w_valid && w_q.nzp_we) begin
            nzp_q <= w_nzp;
         end
      end
   end

   assign o_wb.we    = w_valid && w_q.regfile_we;
   assign o_wb.wsel  = w_q.wsel;
   assign o_wb.wdata = wdata;

   assign o_nzp_cur = (w_valid && w_q.nzp_we) ? w_nzp : nzp_q; // Bypass the NZP register

   assign o_retire.stall      = w_q.stall;
   assign o_retire.pc         = w_q.pc;
   assign o_retire.insn       = w_q.insn;
   assign o_retire.regfile_we = w_q.regfile_we;
   assign o_retire.wsel       = w_q.wsel;
   assign o_retire.wdata      = wdata;
   assign o_retire.nzp_we     = w_q.nzp_we;
   assign o_retire.nzp        = w_nzp;

   // Only an STR opcode in M may write data memory
   a_dmem_we_store : assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> (i_m.insn.rri.opcode == OP_STR))
      else $error("data memory write from a non-store instruction");

endmodule

// ==== src/lc4_core.sv ====
/*
 * LC4 five-stage pipelined core
 * Top level wiring of fetch, decode, execute and memory/writeback
 */
`timescale 1ns/1ps

module lc4_core (
   input  logic              gwe,
   input  logic              i_rst_n,
   output lc4_pkg::word_t    o_imem_addr,
   input  lc4_pkg::word_t    i_imem_data,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_wdata,
   input  lc4_pkg::word_t    i_dmem_rdata,
   output lc4_pkg::retire_t  o_retire
);
   import lc4_pkg::*;

   d_reg_t    d;
   x_reg_t    x;
   m_reg_t    m;
   redirect_t redirect;
   wb_port_t  wb;
   nzp_t      nzp_cur;
   logic      load_use;

   lc4_fetch i_lc4_fetch (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_imem_data (i_imem_data),
      .i_load_use  (load_use),
      .i_redirect  (redirect),
      .o_imem_addr (o_imem_addr),
      .o_d         (d)
   );

   lc4_decode_stage i_lc4_decode_stage (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_d        (d),
      .i_wb       (wb),
      .i_redirect (redirect),
      .o_load_use (load_use),
      .o_x        (x)
   );

   lc4_execute i_lc4_execute (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_x        (x),
      .i_wb       (wb),
      .i_nzp_cur  (nzp_cur),
      .o_redirect (redirect),
      .o_m        (m)
   );

   lc4_writeback i_lc4_writeback (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_m          (m),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_wdata (o_dmem_wdata),
      .o_dmem_we    (o_dmem_we),
      .o_wb         (wb),
      .o_nzp_cur    (nzp_cur),
      .o_retire     (o_retire)
   );

endmodule

// ==== tb/tb_lc4_core.sv ====
/*
 * Testbench for the LC4 pipelined core
 * Instruction and data memory models, stimulus file reader,
 * retirement and store checks, reset check and cycle timeout
 */
`timescale 1ns/1ps

module tb_lc4_core;
   import lc4_pkg::*;

   localparam string STIM_FILE = "tb/lc4_stimulus.txt";

   logic    gwe;
   logic    rst_n;
   word_t   imem_addr;
   word_t   imem_data;
   word_t   dmem_addr;
   word_t   dmem_wdata;
   word_t   dmem_rdata;
   logic    dmem_we;
   retire_t retire;

   word_t   imem [0:65535];
   word_t   dmem [0:65535];
   retire_t exp_retire [$];    // Expected retirements, oldest first
   word_t   exp_st_addr [$];
   word_t   exp_st_data [$];
   int      cycles = 0;
   int      cycle_limit = 0;

   lc4_core i_lc4_core (
      .gwe          (gwe),
      .i_rst_n      (rst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_data  (imem_data),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_we    (dmem_we),
      .o_dmem_wdata (dmem_wdata),
      .i_dmem_rdata (dmem_rdata),
      .o_retire     (retire)
   );

   assign imem_data  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_addr];

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr] <= dmem_wdata;
      end
   end

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   task automatic fail_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare_word(string name, word_t got, word_t exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_retire(retire_t got, retire_t exp);
      compare_word("retire.pc", got.pc, exp.pc);
      compare_word("retire.insn", got.insn, exp.insn);
      compare_word("retire.regfile_we", word_t'(got.regfile_we), word_t'(exp.regfile_we));
      compare_word("retire.nzp_we", word_t'(got.nzp_we), word_t'(exp.nzp_we));
      if (exp.regfile_we) begin        // Data fields only mean something when written
         compare_word("retire.wsel", word_t'(got.wsel), word_t'(exp.wsel));
         compare_word("retire.wdata", got.wdata, exp.wdata);
      end
      if (exp.nzp_we) begin
         compare_word("retire.nzp", word_t'(got.nzp), word_t'(exp.nzp));
      end
   endtask

   task automatic check_store(word_t addr, word_t data, word_t exp_addr, word_t exp_data);
      compare_word("dmem_addr", addr, exp_addr);
      compare_word("dmem_wdata", data, exp_data);
   endtask

   task automatic check_reset_state();
      compare_word("imem_addr", imem_addr, RESET_PC);
      compare_word("dmem_we", word_t'(dmem_we), 16'h0000);
      compare_word("retire.stall", word_t'(retire.stall), word_t'(STALL_FLUSH));
   endtask

   // Unused code reads as opcode F, which retires with no effect
   task automatic fill_memories();
      word_t addr;
      for (int a = 0; a < 65536; a++) begin
         addr       = word_t'(a);
         imem[addr] = {4'hF, addr[11:0] ^ {3{addr[15:12]}}};
         dmem[addr] = {addr[7:0], addr[15:8]} ^ 16'hA5C3;
      end
   endtask

   task automatic load_stimulus();
      int      fd;
      int      n;
      string   line;
      byte     tag;
      word_t   f [7];
      retire_t r;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %s", STIM_FILE);
         fail_run();
      end
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if (line.len() > 1) begin
            tag = line.getc(0);
            n   = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            case (tag)
               "I": imem[f[0]] = f[1];
               "D": dmem[f[0]] = f[1];
               "R": begin
                  r.stall      = STALL_NONE;
                  r.pc         = f[0];
                  r.insn       = f[1];
                  r.regfile_we = f[2][0];
                  r.wsel       = f[3][2:0];
                  r.wdata      = f[4];
                  r.nzp_we     = f[5][0];
                  r.nzp        = f[6][2:0];
                  exp_retire.push_back(r);
               end
               "S": begin
                  exp_st_addr.push_back(f[0]);
                  exp_st_data.push_back(f[1]);
               end
               default: ;                    // Comment line
            endcase
         end
      end
      $fclose(fd);
   endtask

   initial begin
      rst_n = 1'b0;
      fill_memories();
      load_stimulus();
      cycle_limit = 8 * exp_retire.size() + 100;
      repeat (15) @(posedge gwe);
      @(negedge gwe);
      check_reset_state();
      @(posedge gwe);
      rst_n <= 1'b1;
   end

   // Outputs are read mid-cycle, away from the clock edge
   always @(negedge gwe) begin
      if (rst_n) begin
         if (dmem_we) begin
            if (exp_st_addr.size() == 0) begin
               $display("Unexpected data memory write to address %h", dmem_addr);
               fail_run();
            end else begin
               check_store(dmem_addr, dmem_wdata, exp_st_addr.pop_front(),
                           exp_st_data.pop_front());
            end
         end
         if (retire.stall == STALL_NONE) begin
            if (exp_retire.size() == 0) begin
               $display("Unexpected retirement of pc %h", retire.pc);
               fail_run();
            end else begin
               check_retire(retire, exp_retire.pop_front());
               if (exp_retire.size() == 0) begin
                  if (exp_st_addr.size() == 0) begin
                     $display("Simulation completed successfully");
                     $finish;
                  end else begin
                     $display("Program retired with %0d stores still missing",
                              exp_st_addr.size());
                     fail_run();
                  end
               end
            end
         end
      end
   end

   always @(posedge gwe) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles with %0d retirements still expected",
                  cycles, exp_retire.size());
         fail_run();
      end
   end

endmodule

// ==== tb/lc4_stimulus.txt ====
# I addr insn | D addr data | S store_addr store_data (hex)
# R pc insn regfile_we wsel wdata nzp_we nzp, fields unused by the instruction are 0
D 0042 8001
I 8200 9E40  # CONST R7, #64
I 8201 9205  # CONST R1, #5
I 8202 95FD  # CONST R2, #-3
I 8203 1642  # ADD R3, R1, R2
I 8204 18D1  # SUB R4, R3, R1
I 8205 1B27  # ADD R5, R4, #7
I 8206 5D43  # AND R6, R5, R3
I 8207 5D11  # OR R6, R4, R1
I 8208 519A  # XOR R0, R6, R2
I 8209 73C0  # STR R1, R7, #0
I 820A 65C2  # LDR R2, R7, #2
I 820B 1682  # ADD R3, R2, R2
I 820C 77C1  # STR R3, R7, #1
I 820D 69C0  # LDR R4, R7, #0
I 820E 79C3  # STR R4, R7, #3
I 820F 6BC1  # LDR R5, R7, #1
I 8210 0402  # BRz #2
I 8211 0202  # BRp #2
I 8212 9001  # CONST R0, #1
I 8213 9002  # CONST R0, #2
I 8214 137E  # ADD R1, R5, #-2
I 8215 0A01  # BRnp #1
I 8216 0402  # BRz #2
I 8217 9003  # CONST R0, #3
I 8218 71C4  # STR R0, R7, #4
I 8219 6DC2  # LDR R6, R7, #2
I 821A 0802  # BRn #2
I 821B 9C07  # CONST R6, #7
I 821C 9C08  # CONST R6, #8
I 821D 1197  # SUB R0, R6, R7
I 821E A123  # Shift opcode
I 821F 1200  # ADD R1, R0, R0
I 8220 73C5  # STR R1, R7, #5
R 8200 9E40 1 7 0040 1 1
R 8201 9205 1 1 0005 1 1
R 8202 95FD 1 2 FFFD 1 4
R 8203 1642 1 3 0002 1 1
R 8204 18D1 1 4 FFFD 1 4
R 8205 1B27 1 5 0004 1 1
R 8206 5D43 1 6 0000 1 2
R 8207 5D11 1 6 FFFD 1 4
R 8208 519A 1 0 0000 1 2
R 8209 73C0 0 0 0000 0 0
R 820A 65C2 1 2 8001 1 4
R 820B 1682 1 3 0002 1 1
R 820C 77C1 0 0 0000 0 0
R 820D 69C0 1 4 0005 1 1
R 820E 79C3 0 0 0000 0 0
R 820F 6BC1 1 5 0002 1 1
R 8210 0402 0 0 0000 0 0
R 8211 0202 0 0 0000 0 0
R 8214 137E 1 1 0000 1 2
R 8215 0A01 0 0 0000 0 0
R 8216 0402 0 0 0000 0 0
R 8219 6DC2 1 6 8001 1 4
R 821A 0802 0 0 0000 0 0
R 821D 1197 1 0 7FC1 1 1
R 821E A123 0 0 0000 0 0
R 821F 1200 1 1 FF82 1 4
R 8220 73C5 0 0 0000 0 0
S 0040 0005
S 0041 0002
S 0043 0005
S 0045 FF82

// ==== build.f ====
common/lc4_pkg.sv
src/lc4_fetch.sv
decode/lc4_decoder.sv
decode/lc4_regfile.sv
decode/lc4_decode_stage.sv
execute/lc4_execute.sv
src/lc4_writeback.sv
src/lc4_core.sv
tb/tb_lc4_core.sv

// ==== Makefile ====
# Verilator simulation of the LC4 pipelined core

VERILATOR ?= verilator
TOP       ?= tb_lc4_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
